//--- memBusPkg.sv
// Memory bus definitions
`default_nettype none

package memBusPkg;

	//////////////////////////////
	// Bus widths.
	//////////////////////////////

	// Width of one data word on the bus.
	localparam int DATA_WIDTH = 16;
	// Width of one bus address.
	localparam int ADDR_WIDTH = 16;

	//////////////////////////////
	// Run memory geometry.
	//////////////////////////////

	// Words held in the run memory.
	localparam int RUN_MEM_DEPTH = 256;
	// Low address bits that index it; higher bits alias.
	localparam int RUN_MEM_ADDR_BITS = 8;

	//////////////////////////////
	// Map region layout.
	//////////////////////////////

	// Top two address bits that select the map region.
	localparam logic [1:0] MAP_PREFIX = 2'b11;
	// Low address bits that select a map register.
	localparam int MAP_INDEX_BITS = 3;

	// Register indices.
	localparam logic [MAP_INDEX_BITS-1:0] MAP_REG_SCRATCH0 = 3'd0;
	localparam logic [MAP_INDEX_BITS-1:0] MAP_REG_SCRATCH1 = 3'd1;
	localparam logic [MAP_INDEX_BITS-1:0] MAP_REG_PORT     = 3'd2;
	localparam logic [MAP_INDEX_BITS-1:0] MAP_REG_WRCOUNT  = 3'd4;
	localparam logic [MAP_INDEX_BITS-1:0] MAP_REG_ID       = 3'd5;

	// Fixed word returned by the ID register.
	localparam logic [DATA_WIDTH-1:0] MAP_ID_VALUE = 16'h5A01;

endpackage

`default_nettype wire

//--- JtagBridge.sv
// Debug host bus bridge
`timescale 1ns/1ns
`default_nettype none

module JtagBridge (
	input  logic                             i_clk,
	input  logic                             i_reset,

	// Host command strobe.
	input  logic [memBusPkg::ADDR_WIDTH-1:0] i_hostAddr,
	input  logic [memBusPkg::DATA_WIDTH-1:0] i_hostWrData,
	input  logic                             i_hostWr,
	input  logic                             i_hostEn,

	// Registered bus access.
	output logic [memBusPkg::ADDR_WIDTH-1:0] o_busAddr,
	output logic [memBusPkg::DATA_WIDTH-1:0] o_busWrData,
	output logic                             o_busWr,
	output logic                             o_busEn,

	// Sampled data line.
	input  wire  [memBusPkg::DATA_WIDTH-1:0] i_busData,

	// Read response back to the host.
	output logic [memBusPkg::DATA_WIDTH-1:0] o_hostRdData,
	output logic                             o_hostRdValid
);

//////////////////////////////
// Internal state.
//////////////////////////////

// High while the current bus access is a read.
logic rdPending;

//////////////////////////////
// Command stage.
//////////////////////////////

// Control state of the bus access.
// One strobe in gives exactly one access cycle out.
always_ff @(posedge i_clk) begin
	if (i_reset) begin
		o_busEn   <= 1'b0;
		o_busWr   <= 1'b0;
		rdPending <= 1'b0;
	end else begin
		o_busEn   <= i_hostEn;
		o_busWr   <= i_hostEn & i_hostWr;
		rdPending <= i_hostEn & ~i_hostWr;
	end
end

// Payload of the access.
always_ff @(posedge i_clk) begin
	if (i_hostEn) begin
		o_busAddr   <= i_hostAddr;
		o_busWrData <= i_hostWrData;
	end
end

//////////////////////////////
// Response stage.
//////////////////////////////

// Valid strobe trails the read access by one cycle.
always_ff @(posedge i_clk) begin
	if (i_reset) begin
		o_hostRdValid <= 1'b0;
	end else begin
		o_hostRdValid <= rdPending;
	end
end

// Capture the data line at the end of the read access.
always_ff @(posedge i_clk) begin
	if (rdPending) begin
		o_hostRdData <= i_busData;
	end
end

// Back-to-back accesses need back-to-back host strobes.
assert property (@(posedge i_clk) disable iff (i_reset)
	(o_busEn && $past(o_busEn)) |-> ($past(i_hostEn) && $past(i_hostEn, 2)));

endmodule

`default_nettype wire

//--- MemController.sv
// Memory bus controller
`timescale 1ns/1ns
`default_nettype none

module MemController (
	// Bus access from the bridge.
	input  logic [memBusPkg::ADDR_WIDTH-1:0] i_busAddr,
	input  logic [memBusPkg::DATA_WIDTH-1:0] i_busWrData,
	input  logic                             i_busWr,
	input  logic                             i_busEn,

	// Combinational read data of the map block.
	input  logic [memBusPkg::DATA_WIDTH-1:0] i_mapReadData,

	// Decoded memory controls.
	output logic [memBusPkg::ADDR_WIDTH-1:0] o_memAddr,
	output logic                             o_memRunWr,
	output logic                             o_memRunEn,
	output logic                             o_memMapWrEn,

	// Shared data line.
	inout  wire  [memBusPkg::DATA_WIDTH-1:0] io_memData
);

//////////////////////////////
// Decode.
//////////////////////////////

// Access falls in the top quarter of the address space.
logic isMapAddr;
// Map region read, served from the map block.
logic isMapRead;
// Value and enable for the data line driver.
logic [memBusPkg::DATA_WIDTH-1:0] driveData;
logic driveEn;

// Top two bits pick the region.
assign isMapAddr = (i_busAddr[memBusPkg::ADDR_WIDTH-1 -: 2] == memBusPkg::MAP_PREFIX);
assign isMapRead = isMapAddr & i_busEn & ~i_busWr;

//////////////////////////////
// Data line driver.
//////////////////////////////

// Map data on map reads, host data otherwise.
assign driveData = isMapRead ? i_mapReadData : i_busWrData;

// Drive on any write or map read.
// Run reads leave the line to the run memory.
assign driveEn = (i_busEn & i_busWr) | isMapRead;

assign io_memData = driveEn ? driveData : {memBusPkg::DATA_WIDTH{1'bz}};

//////////////////////////////
// Memory controls.
//////////////////////////////

assign o_memAddr    = i_busAddr;
assign o_memRunWr   = i_busWr;
// Run memory stays idle for map accesses.
assign o_memRunEn   = i_busEn & ~isMapAddr;
assign o_memMapWrEn = i_busEn & i_busWr & isMapAddr;

// Region decode keeps the two targets apart.
always_comb begin
	assert final (!(o_memRunEn && o_memMapWrEn));
end

endmodule

`default_nettype wire

//--- RunMemory.sv
// Run memory array
`timescale 1ns/1ns
`default_nettype none

module RunMemory (
	input  logic                             i_clk,

	// Decoded controls.
	input  logic [memBusPkg::ADDR_WIDTH-1:0] i_memAddr,
	input  logic                             i_memRunWr,
	input  logic                             i_memRunEn,

	// Shared data line.
	inout  wire  [memBusPkg::DATA_WIDTH-1:0] io_memData
);

//////////////////////////////
// Storage.
//////////////////////////////

// Word array whose contents are undefined until written.
logic [memBusPkg::DATA_WIDTH-1:0] memArray [memBusPkg::RUN_MEM_DEPTH];

// Only the low bits index the array.
logic [memBusPkg::RUN_MEM_ADDR_BITS-1:0] wordIndex;
// Enabled read of the array.
logic readEn;

assign wordIndex = i_memAddr[memBusPkg::RUN_MEM_ADDR_BITS-1:0];
assign readEn    = i_memRunEn & ~i_memRunWr;

// Write lands at the end of the access cycle.
always_ff @(posedge i_clk) begin
	if (i_memRunEn && i_memRunWr) begin
		memArray[wordIndex] <= io_memData;
	end
end

//////////////////////////////
// Read driver.
//////////////////////////////

// Combinational read onto the line.
// Released whenever this is not a run read.
assign io_memData = readEn ? memArray[wordIndex] : {memBusPkg::DATA_WIDTH{1'bz}};

endmodule

`default_nettype wire

//--- MapRegisters.sv
// Mapped register block
`timescale 1ns/1ns
`default_nettype none

module MapRegisters (
	input  logic                             i_clk,
	input  logic                             i_reset,

	// Decoded map controls.
	input  logic [memBusPkg::ADDR_WIDTH-1:0] i_memAddr,
	input  logic                             i_memMapWrEn,
	input  wire  [memBusPkg::DATA_WIDTH-1:0] i_memData,

	// Combinational read data back to the controller.
	output logic [memBusPkg::DATA_WIDTH-1:0] o_mapReadData,

	// Port register value.
	output logic [memBusPkg::DATA_WIDTH-1:0] o_portOut
);

//////////////////////////////
// Registers.
//////////////////////////////

// Low address bits pick the register and alias every 8 words.
logic [memBusPkg::MAP_INDEX_BITS-1:0] regIndex;

// Read-write words.
logic [memBusPkg::DATA_WIDTH-1:0] scratch0;
logic [memBusPkg::DATA_WIDTH-1:0] scratch1;
logic [memBusPkg::DATA_WIDTH-1:0] portReg;
// Wrapping count of accepted map writes.
logic [memBusPkg::DATA_WIDTH-1:0] wrCount;

assign regIndex = i_memAddr[memBusPkg::MAP_INDEX_BITS-1:0];

// Writes land at the end of the access cycle.
always_ff @(posedge i_clk) begin
	if (i_reset) begin
		scratch0 <= '0;
		scratch1 <= '0;
		portReg  <= '0;
		wrCount  <= '0;
	end else if (i_memMapWrEn) begin
		// Every map write counts, even to read-only words.
		wrCount <= wrCount + 1'b1;
		case (regIndex)
			memBusPkg::MAP_REG_SCRATCH0: scratch0 <= i_memData;
			memBusPkg::MAP_REG_SCRATCH1: scratch1 <= i_memData;
			memBusPkg::MAP_REG_PORT:     portReg  <= i_memData;
			// Read-only and unused words ignore the data.
			default: ;
		endcase
	end
end

//////////////////////////////
// Read mux.
//////////////////////////////

always_comb begin
	case (regIndex)
		memBusPkg::MAP_REG_SCRATCH0: o_mapReadData = scratch0;
		memBusPkg::MAP_REG_SCRATCH1: o_mapReadData = scratch1;
		memBusPkg::MAP_REG_PORT:     o_mapReadData = portReg;
		memBusPkg::MAP_REG_WRCOUNT:  o_mapReadData = wrCount;
		memBusPkg::MAP_REG_ID:       o_mapReadData = memBusPkg::MAP_ID_VALUE;
		// Unused indices read zero.
		default:                     o_mapReadData = '0;
	endcase
end

// Port output follows the register directly.
assign o_portOut = portReg;

endmodule

`default_nettype wire

//--- MemSubsystem.sv
// Memory bus subsystem top
`timescale 1ns/1ns
`default_nettype none

module MemSubsystem (
	input  logic                             i_clk,
	input  logic                             i_reset,

	// Host command port.
	input  logic [memBusPkg::ADDR_WIDTH-1:0] i_hostAddr,
	input  logic [memBusPkg::DATA_WIDTH-1:0] i_hostWrData,
	input  logic                             i_hostWr,
	input  logic                             i_hostEn,

	// Host read response.
	output logic [memBusPkg::DATA_WIDTH-1:0] o_hostRdData,
	output logic                             o_hostRdValid,

	// Port register value.
	output logic [memBusPkg::DATA_WIDTH-1:0] o_portOut
);

//////////////////////////////
// Nets.
//////////////////////////////

// Bridge to controller.
logic [memBusPkg::ADDR_WIDTH-1:0] busAddr;
logic [memBusPkg::DATA_WIDTH-1:0] busWrData;
logic                             busWr;
logic                             busEn;

// Controller to memories.
logic [memBusPkg::ADDR_WIDTH-1:0] memAddr;
logic                             memRunWr;
logic                             memRunEn;
logic                             memMapWrEn;
logic [memBusPkg::DATA_WIDTH-1:0] mapReadData;

// Shared tristate data line.
// Driven by the controller or the run memory, never both.
wire  [memBusPkg::DATA_WIDTH-1:0] memData;

//////////////////////////////
// Blocks.
//////////////////////////////

JtagBridge bridge0 (
	.i_clk         (i_clk),
	.i_reset       (i_reset),
	.i_hostAddr    (i_hostAddr),
	.i_hostWrData  (i_hostWrData),
	.i_hostWr      (i_hostWr),
	.i_hostEn      (i_hostEn),
	.o_busAddr     (busAddr),
	.o_busWrData   (busWrData),
	.o_busWr       (busWr),
	.o_busEn       (busEn),
	.i_busData     (memData),
	.o_hostRdData  (o_hostRdData),
	.o_hostRdValid (o_hostRdValid)
);

MemController ctrl0 (
	.i_busAddr     (busAddr),
	.i_busWrData   (busWrData),
	.i_busWr       (busWr),
	.i_busEn       (busEn),
	.i_mapReadData (mapReadData),
	.o_memAddr     (memAddr),
	.o_memRunWr    (memRunWr),
	.o_memRunEn    (memRunEn),
	.o_memMapWrEn  (memMapWrEn),
	.io_memData    (memData)
);

RunMemory runMem0 (
	.i_clk      (i_clk),
	.i_memAddr  (memAddr),
	.i_memRunWr (memRunWr),
	.i_memRunEn (memRunEn),
	.io_memData (memData)
);

MapRegisters mapRegs0 (
	.i_clk         (i_clk),
	.i_reset       (i_reset),
	.i_memAddr     (memAddr),
	.i_memMapWrEn  (memMapWrEn),
	.i_memData     (memData),
	.o_mapReadData (mapReadData),
	.o_portOut     (o_portOut)
);

endmodule

`default_nettype wire

//--- MemChecker.sv
// Memory subsystem response checker
`timescale 1ns/1ns
`default_nettype none

module MemChecker (
	input  logic                             i_clk,
	input  logic                             i_reset,

	// Host command as driven into the DUT.
	input  logic [memBusPkg::ADDR_WIDTH-1:0] i_hostAddr,
	input  logic [memBusPkg::DATA_WIDTH-1:0] i_hostWrData,
	input  logic                             i_hostWr,
	input  logic                             i_hostEn,

	// DUT outputs under watch.
	input  logic [memBusPkg::DATA_WIDTH-1:0] i_hostRdData,
	input  logic                             i_hostRdValid,
	input  logic [memBusPkg::DATA_WIDTH-1:0] i_portOut,

	// Running totals for the closing report.
	output int                               o_errorCount,
	output int                               o_pendingCount
);

localparam int MAX_VECTORS = 64;

//////////////////////////////
// Expected data.
//////////////////////////////

// Raw vector words with three per line.
logic [15:0] vecWords [3*MAX_VECTORS];
// Expected read data in file order.
logic [memBusPkg::DATA_WIDTH-1:0] expectQ [$];
logic [memBusPkg::DATA_WIDTH-1:0] expectWord;

// Two-cycle delay lines for read strobes and port writes.
logic [1:0] rdStage;
logic [1:0] portStage;
logic [memBusPkg::DATA_WIDTH-1:0] portData [2];

// Host write that lands in the port register.
logic isPortWrite;

assign isPortWrite = i_hostEn && i_hostWr &&
	(i_hostAddr[memBusPkg::ADDR_WIDTH-1 -: 2] == memBusPkg::MAP_PREFIX) &&
	(i_hostAddr[memBusPkg::MAP_INDEX_BITS-1:0] == memBusPkg::MAP_REG_PORT);

// Op bit 0 clear marks a read line.
initial begin
	o_errorCount = 0;
	rdStage = 2'b00;
	portStage = 2'b00;
	foreach (vecWords[i]) begin
		vecWords[i] = 16'hFFFF;
	end
	$readmemh("memVectors.txt", vecWords);
	for (int i = 0; i < MAX_VECTORS && vecWords[3*i] != 16'hFFFF; i++) begin
		if (!vecWords[3*i][0]) begin
			expectQ.push_back(vecWords[3*i+2]);
		end
	end
	o_pendingCount = expectQ.size();
end

//////////////////////////////
// Compare.
//////////////////////////////

always @(posedge i_clk) begin
	if (i_reset) begin
		rdStage = 2'b00;
		portStage = 2'b00;
	end else begin
		// Response trails its read strobe by exactly two cycles.
		if (i_hostRdValid !== rdStage[1]) begin
			$display("ERROR at %0t ns: read valid %b, expected %b", $time, i_hostRdValid,
				rdStage[1]);
			o_errorCount = o_errorCount + 1;
		end
		if (i_hostRdValid === 1'b1) begin
			if (expectQ.size() == 0) begin
				$display("ERROR at %0t ns: read response with no read outstanding", $time);
				o_errorCount = o_errorCount + 1;
			end else begin
				expectWord = expectQ.pop_front();
				if (i_hostRdData !== expectWord) begin
					$display("ERROR at %0t ns: read data %h, expected %h", $time,
						i_hostRdData, expectWord);
					o_errorCount = o_errorCount + 1;
				end
			end
		end
		// Port output shows the write two cycles after its strobe.
		if (portStage[1] && i_portOut !== portData[1]) begin
			$display("ERROR at %0t ns: port out %h, expected %h", $time, i_portOut,
				portData[1]);
			o_errorCount = o_errorCount + 1;
		end
		portStage = {portStage[0], isPortWrite};
		portData[1] = portData[0];
		portData[0] = i_hostWrData;
		rdStage = {rdStage[0], i_hostEn && !i_hostWr};
	end
	o_pendingCount = expectQ.size();
end

endmodule

`default_nettype wire

//--- tbMemSubsystem.sv
// Memory subsystem testbench
`timescale 1ns/1ns
`default_nettype none

module tbMemSubsystem;

localparam int MAX_VECTORS = 64;

logic        clk;
logic        reset;
logic [15:0] hostAddr;
logic [15:0] hostWrData;
logic        hostWr;
logic        hostEn;
logic [15:0] hostRdData;
logic        hostRdValid;
logic [15:0] portOut;
int          errorCount;
int          pendingCount;

// Vector words with three per line and the line count.
logic [15:0] vecWords [3*MAX_VECTORS];
int          vecCount;
logic        vectorsLoaded;
int          watchdogCycles;

MemSubsystem dut0 (
	.i_clk         (clk),
	.i_reset       (reset),
	.i_hostAddr    (hostAddr),
	.i_hostWrData  (hostWrData),
	.i_hostWr      (hostWr),
	.i_hostEn      (hostEn),
	.o_hostRdData  (hostRdData),
	.o_hostRdValid (hostRdValid),
	.o_portOut     (portOut)
);

MemChecker checker0 (
	.i_clk          (clk),
	.i_reset        (reset),
	.i_hostAddr     (hostAddr),
	.i_hostWrData   (hostWrData),
	.i_hostWr       (hostWr),
	.i_hostEn       (hostEn),
	.i_hostRdData   (hostRdData),
	.i_hostRdValid  (hostRdValid),
	.i_portOut      (portOut),
	.o_errorCount   (errorCount),
	.o_pendingCount (pendingCount)
);

// 4 ns clock.
initial begin
	clk = 1'b0;
end
always #2 clk = ~clk;

//////////////////////////////
// Stimulus.
//////////////////////////////

initial begin
	logic [15:0] op;
	int gap;
	int drainCycles;
	reset = 1'b1;
	hostAddr = '0;
	hostWrData = '0;
	hostWr = 1'b0;
	hostEn = 1'b0;
	vectorsLoaded = 1'b0;
	void'($urandom(32'h0719eae2));
	foreach (vecWords[i]) begin
		vecWords[i] = 16'hFFFF;
	end
	$readmemh("memVectors.txt", vecWords);
	vecCount = 0;
	while (vecCount < MAX_VECTORS && vecWords[3*vecCount] != 16'hFFFF) begin
		vecCount++;
	end
	vectorsLoaded = 1'b1;
	if (vecCount == 0) begin
		$display("No commands were read from memVectors.txt.");
	end
	repeat (5) @(posedge clk);
	#1;
	reset = 1'b0;
	for (int i = 0; i < vecCount; i++) begin
		op = vecWords[3*i];
		// Ops 10 and 11 follow the previous command with no idle cycle.
		gap = op[4] ? 0 : $urandom % 3;
		repeat (gap) begin
			@(posedge clk);
			#1;
			hostEn = 1'b0;
		end
		@(posedge clk);
		#1;
		hostAddr = vecWords[3*i+1];
		hostWrData = vecWords[3*i+2];
		hostWr = op[0];
		hostEn = 1'b1;
	end
	@(posedge clk);
	#1;
	hostEn = 1'b0;
	// Wait for the last responses, then for the last port check.
	drainCycles = 0;
	while (pendingCount != 0 && drainCycles < 8) begin
		@(posedge clk);
		#1;
		drainCycles++;
	end
	repeat (3) @(posedge clk);
	#1;
	$display("Errors: %0d, missing responses: %0d", errorCount, pendingCount);
	if (errorCount == 0 && pendingCount == 0 && vecCount > 0) begin
		$display("ALL TESTS PASSED");
	end else begin
		$display("SOME TESTS FAILED");
	end
	$finish;
end

// Watchdog sized from the command count.
initial begin
	wait (vectorsLoaded);
	watchdogCycles = vecCount * 4 + 40;
	repeat (watchdogCycles) @(posedge clk);
	$display("Watchdog expired after %0d cycles and the run did not finish.", watchdogCycles);
	$display("SOME TESTS FAILED");
	$finish;
end

endmodule

`default_nettype wire

//--- memVectors.txt
// Columns: op, address, data, all hex. Op 0 reads, op 1 writes, ops 10 and 11 do the same
// with no idle cycle before them. On a read the data column is the expected read data.
1 0000 1111
1 0010 1234
10 0010 1234
1 0123 BEEF
0 0023 BEEF
1 8223 CAFE
10 0123 CAFE
1 C000 A5A5
1 C001 5A5A
1 C002 00FF
0 C000 A5A5
10 C001 5A5A
0 C00A 00FF
11 FFF2 1357
0 C002 1357
1 C004 FFFF
11 C005 0000
1 C003 9999
0 C004 0007
10 C005 5A01
0 C003 0000
0 0000 1111
1 4000 2222
10 C000 A5A5
0 0000 2222

//--- build.f
memBusPkg.sv
JtagBridge.sv
MemController.sv
RunMemory.sv
MapRegisters.sv
MemSubsystem.sv
MemChecker.sv
tbMemSubsystem.sv

//--- Bender.yml
package:
  name: mem_subsystem

sources:
  - memBusPkg.sv
  - JtagBridge.sv
  - MemController.sv
  - RunMemory.sv
  - MapRegisters.sv
  - MemSubsystem.sv
  - target: test
    files:
      - MemChecker.sv
      - tbMemSubsystem.sv
